/* all.f */
// package first, then leaf modules up to the top, then the testbench
+incdir+testbench
verilog/vec_alu_pkg.sv
verilog/vec_alu_addsub.sv
verilog/vec_alu_shift.sv
verilog/vec_alu_logic.sv
verilog/vec_alu_unit.sv
verilog/vec_alu_rs_fifo.sv
verilog/vec_alu_cluster.sv
verilog/vec_alu_top.sv
testbench/tb_vec_alu.sv

/* build.sh */
#!/usr/bin/env bash
# compile and run the vector alu testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module tb_vec_alu \
  --Mdir build/obj_dir -o sim_tb_vec_alu

./build/obj_dir/sim_tb_vec_alu | tee build/sim.log

if grep -q "ERRORS FOUND" build/sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "NO ERRORS" build/sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi
echo "simulation passed"

/* testbench/tb_vec_alu_model.svh */
`ifndef TB_VEC_ALU_MODEL_SVH
`define TB_VEC_ALU_MODEL_SVH

// one element of width w, a and b already cut to w bits
function automatic logic [63:0] elem_result(input vec_alu_pkg::alu_op_e op, input int w,
                                            input logic [63:0] a, input logic [63:0] b);
  logic [63:0] mask;
  logic [63:0] sext;
  int          amt;
  mask = (64'd1 << w) - 64'd1;
  // only log2(w) bits of the shift amount count
  amt  = int'(b[4:0]) & (w - 1);
  // sign extended copy for sra
  sext = a[w-1] ? (a | ~mask) : a;
  case (op)
    vec_alu_pkg::op_add: elem_result = (a + b) & mask;
    vec_alu_pkg::op_sub: elem_result = (a - b) & mask;
    vec_alu_pkg::op_sll: elem_result = (a << amt) & mask;
    vec_alu_pkg::op_srl: elem_result = a >> amt;
    vec_alu_pkg::op_sra: elem_result = 64'($signed(sext) >>> amt) & mask;
    default:             elem_result = 64'd0;
  endcase
endfunction

// index of lowest set bit, all ones when none
function automatic logic [63:0] lowest_set(input logic [63:0] v);
  logic [63:0] r;
  logic        found;
  r     = '1;
  found = 1'b0;
  for (int j = 0; j < 64; j++) begin
    if (v[j] && !found) begin
      r     = 64'(j);
      found = 1'b1;
    end
  end
  return r;
endfunction

// full 64-bit result for any opcode and sew
function automatic logic [63:0] expected_result(input vec_alu_pkg::alu_op_e op,
                                                input vec_alu_pkg::sew_e sew,
                                                input logic [63:0] vs1, input logic [63:0] vs2);
  logic [63:0] res;
  logic [63:0] mask;
  int          w;
  w    = 8 << int'(sew);
  mask = (64'd1 << w) - 64'd1;
  res  = '0;
  case (op)
    // bitwise ops ignore element boundaries
    vec_alu_pkg::op_and:    res = vs2 & vs1;
    vec_alu_pkg::op_or:     res = vs2 | vs1;
    vec_alu_pkg::op_xor:    res = vs2 ^ vs1;
    vec_alu_pkg::op_vfirst: res = lowest_set(vs2);
    default: begin
      for (int e = 0; e < 64 / w; e++) begin
        res = res | (elem_result(op, w, (vs2 >> (e * w)) & mask, (vs1 >> (e * w)) & mask)
                     << (e * w));
      end
    end
  endcase
  return res;
endfunction

`endif

/* testbench/tb_vec_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vec_alu;

  `include "tb_vec_alu_model.svh"

  localparam int num_alu  = vec_alu_pkg::num_alu;
  localparam int num_tags = 1 << vec_alu_pkg::rob_idx_w;
  localparam int num_uops = 400;
  // about seven cycles per uop under random stalls, plus the scripted phases
  localparam int max_cycles = num_uops * 7 + 200;

  // stimulus modes, changed only half a cycle away from the drive slot
  localparam int m_idle   = 0;
  localparam int m_random = 1;
  localparam int m_stall  = 2;
  localparam int m_both   = 3;
  localparam int m_hold0  = 4;
  localparam int m_drain  = 5;

  logic                                        clk;
  logic                                        rst_n;
  logic                                        push;
  vec_alu_pkg::alu_op_e                        push_op;
  vec_alu_pkg::sew_e                           push_sew;
  vec_alu_pkg::vreg_t                          push_vs1;
  vec_alu_pkg::vreg_t                          push_vs2;
  vec_alu_pkg::rob_idx_t                       push_rob_idx;
  logic                                        full;
  logic                  [num_alu-1:0]         result_valid;
  vec_alu_pkg::vreg_t    [num_alu-1:0]         result;
  vec_alu_pkg::rob_idx_t [num_alu-1:0]         result_rob_idx;
  logic                  [num_alu-1:0]         result_ready;

  // scoreboard indexed by rob tag
  vec_alu_pkg::vreg_t expected [num_tags];
  logic               pending  [num_tags];

  integer seed;
  int     mode;
  int     pushed;
  int     received;
  int     errors;
  int     cycles;
  int     dual_cnt;
  int     unit1_cnt;

  // last sample, for the hold check
  logic                  [num_alu-1:0] hold_prev;
  vec_alu_pkg::vreg_t    [num_alu-1:0] result_prev;
  vec_alu_pkg::rob_idx_t [num_alu-1:0] tag_prev;

  vec_alu_top dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .push           (push),
    .push_op        (push_op),
    .push_sew       (push_sew),
    .push_vs1       (push_vs1),
    .push_vs2       (push_vs2),
    .push_rob_idx   (push_rob_idx),
    .full           (full),
    .result_valid   (result_valid),
    .result         (result),
    .result_rob_idx (result_rob_idx),
    .result_ready   (result_ready)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // one cycle of readies and maybe one push
  task automatic drive_inputs();
    logic [31:0] rnd;
    logic [31:0] rnd_op;
    logic [31:0] rnd_sew;
    int          tag;
    rnd     = $random(seed);
    rnd_op  = $random(seed);
    rnd_sew = $random(seed);
    case (mode)
      m_random: result_ready = num_alu'($random(seed));
      m_both, m_drain: result_ready = '1;
      m_hold0: begin
        result_ready    = '1;
        result_ready[0] = 1'b0;
      end
      default: result_ready = '0;
    endcase
    tag = pushed % num_tags;
    // a tag is reused only after its result came back
    if (mode != m_idle && !full && pushed < num_uops && !pending[tag] && rnd[1:0] != 2'b00) begin
      push         = 1'b1;
      push_op      = vec_alu_pkg::alu_op_e'(4'(rnd_op % 9));
      push_sew     = vec_alu_pkg::sew_e'(2'(rnd_sew % 3));
      push_vs1     = {$random(seed), $random(seed)};
      push_vs2     = {$random(seed), $random(seed)};
      // all ones stresses carry chains
      if (rnd[4:2] == 3'd0) begin
        push_vs2 = '1;
      end
      if (rnd[7:5] == 3'd0) begin
        push_vs1 = '1;
      end
      // spread vfirst over all indices, sometimes no bit at all
      if (push_op == vec_alu_pkg::op_vfirst) begin
        push_vs2 = push_vs2 << rnd[13:8];
        if (rnd[15:14] == 2'd0) begin
          push_vs2 = '0;
        end
      end
      push_rob_idx  = vec_alu_pkg::rob_idx_t'(tag);
      expected[tag] = expected_result(push_op, push_sew, push_vs1, push_vs2);
      pending[tag]  = 1'b1;
      pushed++;
    end else begin
      push = 1'b0;
    end
  endtask

  // transfers and hold checks, sampled mid cycle
  task automatic score_results();
    int tag;
    for (int i = 0; i < num_alu; i++) begin
      if (hold_prev[i]) begin
        check_value($sformatf("result_valid[%0d]", i), 64'(result_valid[i]), 64'd1);
        check_value($sformatf("result[%0d]", i), result[i], result_prev[i]);
        check_value($sformatf("result_rob_idx[%0d]", i), 64'(result_rob_idx[i]),
                    64'(tag_prev[i]));
      end
      if (result_valid[i] && result_ready[i]) begin
        tag = int'(result_rob_idx[i]);
        if (!pending[tag]) begin
          $display("ERROR at %0t: unit %0d returned tag %0d with no uop outstanding",
                   $time, i, tag);
          errors++;
        end else begin
          check_value($sformatf("result[%0d] tag %0d", i, tag), result[i], expected[tag]);
          pending[tag] = 1'b0;
          received++;
          if (mode == m_hold0 && i == 1) begin
            unit1_cnt++;
          end
        end
      end
      hold_prev[i]   = result_valid[i] && !result_ready[i];
      result_prev[i] = result[i];
      tag_prev[i]    = result_rob_idx[i];
    end
    if (mode == m_both && (&result_valid)) begin
      dual_cnt++;
    end
  endtask

  // next mid cycle slot, clear of drive and sample times
  task automatic step();
    @(negedge clk);
    #1;
  endtask

  task automatic wait_pushed(input int n);
    while (pushed < n) begin
      step();
    end
  endtask

  always @(posedge clk) begin
    #1;
    drive_inputs();
  end

  always @(negedge clk) begin
    if (rst_n) begin
      score_results();
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", max_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    seed         = 14;
    mode         = m_idle;
    pushed       = 0;
    received     = 0;
    errors       = 0;
    dual_cnt     = 0;
    unit1_cnt    = 0;
    hold_prev    = '0;
    rst_n        = 1'b0;
    push         = 1'b0;
    push_op      = vec_alu_pkg::op_add;
    push_sew     = vec_alu_pkg::sew_e8;
    push_vs1     = '0;
    push_vs2     = '0;
    push_rob_idx = '0;
    result_ready = '0;
    for (int t = 0; t < num_tags; t++) begin
      pending[t] = 1'b0;
    end
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    step();
    // nothing valid or full out of reset
    check_value("result_valid", 64'(result_valid), 64'd0);
    check_value("full", 64'(full), 64'd0);

    // random traffic and back-pressure
    mode = m_random;
    wait_pushed(300);

    // stall both units so the fifo fills, then release both
    mode = m_stall;
    repeat (12) step();
    mode = m_both;
    wait_pushed(360);
    if (dual_cnt == 0) begin
      $display("ERROR: both units never showed a result in the same cycle");
      errors++;
    end

    // unit 0 blocked, in-order issue starves unit 1 after its pending result
    mode = m_hold0;
    repeat (40) step();
    check_value("result_valid[0]", 64'(result_valid[0]), 64'd1);
    check_value("full", 64'(full), 64'd1);
    if (unit1_cnt > 1) begin
      $display("ERROR: unit 1 returned %0d results while unit 0 was blocked", unit1_cnt);
      errors++;
    end

    // finish the pushes and drain everything
    mode = m_drain;
    while (pushed < num_uops || received != pushed) begin
      step();
    end
    repeat (4) step();
    check_value("result_valid", 64'(result_valid), 64'd0);
    for (int t = 0; t < num_tags; t++) begin
      if (pending[t]) begin
        $display("ERROR: tag %0d was pushed but its result never came back", t);
        errors++;
      end
    end

    $display("done: %0d uops pushed, %0d results received, %0d errors",
             pushed, received, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/vec_alu_addsub.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_alu_addsub (
  input  wire vec_alu_pkg::vreg_t     a,
  input  wire vec_alu_pkg::vreg_t     b,
  input  wire logic                   sub,
  input  wire vec_alu_pkg::elem_mask_t carry_break,
  output vec_alu_pkg::vreg_t          sum
);

  // b after optional inversion
  vec_alu_pkg::vreg_t b_eff;
  // one 8-bit adder with carry out
  logic [8:0]         slice;
  // carry into the current byte slice
  logic               cin;

  // a - b is a + ~b + 1 per element
  assign b_eff = sub ? ~b : b;

  always_comb begin
    cin   = sub;
    slice = '0;
    for (int k = 0; k < vec_alu_pkg::vlen_bytes; k++) begin
      // element start takes the +1 of sub, else the chained carry
      if (carry_break[k]) begin
        cin = sub;
      end
      slice = {1'b0, a[8*k +: 8]} + {1'b0, b_eff[8*k +: 8]} + {8'd0, cin};
      sum[8*k +: 8] = slice[7:0];
      // ripple into the next byte
      cin = slice[8];
    end
  end

endmodule

`default_nettype wire

/* verilog/vec_alu_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_alu_cluster (
  input  wire logic                                            clk,
  input  wire logic                                            rst_n,
  // head window of the reservation station
  input  wire vec_alu_pkg::alu_op_e  [vec_alu_pkg::num_alu-1:0] head_op,
  input  wire vec_alu_pkg::sew_e     [vec_alu_pkg::num_alu-1:0] head_sew,
  input  wire vec_alu_pkg::vreg_t    [vec_alu_pkg::num_alu-1:0] head_vs1,
  input  wire vec_alu_pkg::vreg_t    [vec_alu_pkg::num_alu-1:0] head_vs2,
  input  wire vec_alu_pkg::rob_idx_t [vec_alu_pkg::num_alu-1:0] head_rob_idx,
  input  wire logic                                            empty,
  input  wire logic                  [vec_alu_pkg::num_alu-1:1] almost_empty,
  output logic                       [vec_alu_pkg::num_alu-1:0] pop,
  // per unit result ports
  output logic                       [vec_alu_pkg::num_alu-1:0] result_valid,
  output vec_alu_pkg::vreg_t         [vec_alu_pkg::num_alu-1:0] result,
  output vec_alu_pkg::rob_idx_t      [vec_alu_pkg::num_alu-1:0] result_rob_idx,
  input  wire logic                  [vec_alu_pkg::num_alu-1:0] result_ready
);

  // head entry i exists
  logic [vec_alu_pkg::num_alu-1:0] uop_valid;
  logic [vec_alu_pkg::num_alu-1:0] can_accept;

  genvar i;

  assign uop_valid[0] = !empty;
  assign pop[0]       = uop_valid[0] && can_accept[0];

  generate
    for (i = 1; i < vec_alu_pkg::num_alu; i = i + 1) begin : g_chain
      // entry i needs more than i entries in the fifo
      assign uop_valid[i] = !(empty || (|almost_empty[i:1]));
      // in order, unit i issues only behind unit i-1
      assign pop[i] = uop_valid[i] && can_accept[i] && pop[i-1];
    end

    for (i = 0; i < vec_alu_pkg::num_alu; i = i + 1) begin : g_unit
      vec_alu_unit u_alu_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue          (pop[i]),
        .uop_op         (head_op[i]),
        .uop_sew        (head_sew[i]),
        .uop_vs1        (head_vs1[i]),
        .uop_vs2        (head_vs2[i]),
        .uop_rob_idx    (head_rob_idx[i]),
        .can_accept     (can_accept[i]),
        .result_valid   (result_valid[i]),
        .result         (result[i]),
        .result_rob_idx (result_rob_idx[i]),
        .result_ready   (result_ready[i])
      );
    end
  endgenerate

endmodule

`default_nettype wire

/* verilog/vec_alu_logic.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_alu_logic (
  input  wire vec_alu_pkg::vreg_t   vs2,
  input  wire vec_alu_pkg::vreg_t   vs1,
  input  wire vec_alu_pkg::alu_op_e op,
  output vec_alu_pkg::vreg_t        result
);

  // lowest set bit index of vs2
  vec_alu_pkg::bit_idx_t first_idx;

  // scan down so the lowest hit is written last
  always_comb begin
    first_idx = '0;
    for (int j = vec_alu_pkg::vlen - 1; j >= 0; j--) begin
      if (vs2[j]) begin
        first_idx = vec_alu_pkg::bit_idx_t'(j);
      end
    end
  end

  // same gates serve regular and mask logicals
  always_comb begin
    case (op)
      vec_alu_pkg::op_and: result = vs2 & vs1;
      vec_alu_pkg::op_or:  result = vs2 | vs1;
      vec_alu_pkg::op_xor: result = vs2 ^ vs1;
      // no set bit reads back as -1
      vec_alu_pkg::op_vfirst: begin
        result = (vs2 == '0) ? '1 : vec_alu_pkg::vreg_t'(first_idx);
      end
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/vec_alu_pkg.sv */
`default_nettype none

package vec_alu_pkg;

  // vector slice width seen by one alu unit
  localparam int vlen = 64;
  // bytes per slice, one adder slice each
  localparam int vlen_bytes = vlen / 8;
  // bits needed to index a bit in the slice
  localparam int bit_idx_w = $clog2(vlen);

  // parallel alu units behind the reservation station
  localparam int num_alu = 2;

  // reservation station entries, power of two
  localparam int rs_depth = 8;
  localparam int rs_ptr_w = $clog2(rs_depth);
  // count must also hold rs_depth itself
  localparam int rs_cnt_w = $clog2(rs_depth + 1);

  // rob tag width
  localparam int rob_idx_w = 5;

  typedef logic [vlen-1:0]       vreg_t;
  typedef logic [rob_idx_w-1:0]  rob_idx_t;
  // one bit per byte slice, set where a new element starts
  typedef logic [vlen_bytes-1:0] elem_mask_t;
  typedef logic [bit_idx_w-1:0]  bit_idx_t;
  typedef logic [rs_ptr_w-1:0]   rs_ptr_t;
  typedef logic [rs_cnt_w-1:0]   rs_cnt_t;

  // integer alu opcodes
  typedef enum logic [3:0] {
    op_add    = 4'd0,
    op_sub    = 4'd1,
    op_sll    = 4'd2,
    op_srl    = 4'd3,
    op_sra    = 4'd4,
    op_and    = 4'd5,
    op_or     = 4'd6,
    op_xor    = 4'd7,
    op_vfirst = 4'd8
  } alu_op_e;

  // element width, encoded as log2(sew/8)
  typedef enum logic [1:0] {
    sew_e8  = 2'd0,
    sew_e16 = 2'd1,
    sew_e32 = 2'd2
  } sew_e;

endpackage

`default_nettype wire

/* verilog/vec_alu_rs_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_alu_rs_fifo (
  input  wire  logic                                            clk,
  input  wire  logic                                            rst_n,
  // one entry per cycle from dispatch
  input  wire  logic                                            push,
  input  wire  vec_alu_pkg::alu_op_e                            push_op,
  input  wire  vec_alu_pkg::sew_e                               push_sew,
  input  wire  vec_alu_pkg::vreg_t                              push_vs1,
  input  wire  vec_alu_pkg::vreg_t                              push_vs2,
  input  wire  vec_alu_pkg::rob_idx_t                           push_rob_idx,
  output logic                                                  full,
  output logic                                                  empty,
  output logic                 [vec_alu_pkg::num_alu-1:1]       almost_empty,
  // oldest num_alu entries, head_*[0] is the oldest
  output vec_alu_pkg::alu_op_e [vec_alu_pkg::num_alu-1:0]       head_op,
  output vec_alu_pkg::sew_e    [vec_alu_pkg::num_alu-1:0]       head_sew,
  output vec_alu_pkg::vreg_t   [vec_alu_pkg::num_alu-1:0]       head_vs1,
  output vec_alu_pkg::vreg_t   [vec_alu_pkg::num_alu-1:0]       head_vs2,
  output vec_alu_pkg::rob_idx_t [vec_alu_pkg::num_alu-1:0]      head_rob_idx,
  input  wire  logic           [vec_alu_pkg::num_alu-1:0]       pop
);

  // entry storage
  vec_alu_pkg::alu_op_e  mem_op      [vec_alu_pkg::rs_depth];
  vec_alu_pkg::sew_e     mem_sew     [vec_alu_pkg::rs_depth];
  vec_alu_pkg::vreg_t    mem_vs1     [vec_alu_pkg::rs_depth];
  vec_alu_pkg::vreg_t    mem_vs2     [vec_alu_pkg::rs_depth];
  vec_alu_pkg::rob_idx_t mem_rob_idx [vec_alu_pkg::rs_depth];

  vec_alu_pkg::rs_ptr_t rd_ptr;
  vec_alu_pkg::rs_ptr_t wr_ptr;
  vec_alu_pkg::rs_cnt_t count;
  vec_alu_pkg::rs_cnt_t pop_cnt;
  logic                 push_en;

  // a push into a full buffer is dropped
  assign push_en = push && !full;

  // pop is a prefix, so its popcount is the advance
  always_comb begin
    pop_cnt = '0;
    for (int i = 0; i < vec_alu_pkg::num_alu; i++) begin
      pop_cnt = pop_cnt + vec_alu_pkg::rs_cnt_t'(pop[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap on their own since rs_depth is a power of two
      rd_ptr <= rd_ptr + vec_alu_pkg::rs_ptr_t'(pop_cnt);
      if (push_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      count <= count + vec_alu_pkg::rs_cnt_t'(push_en) - pop_cnt;
    end
  end

  always_ff @(posedge clk) begin
    if (push_en) begin
      mem_op[wr_ptr]      <= push_op;
      mem_sew[wr_ptr]     <= push_sew;
      mem_vs1[wr_ptr]     <= push_vs1;
      mem_vs2[wr_ptr]     <= push_vs2;
      mem_rob_idx[wr_ptr] <= push_rob_idx;
    end
  end

  assign full  = (count == vec_alu_pkg::rs_cnt_t'(vec_alu_pkg::rs_depth));
  assign empty = (count == '0);

  // head window and the occupancy flags per unit
  genvar i;
  generate
    for (i = 0; i < vec_alu_pkg::num_alu; i = i + 1) begin : g_head
      assign head_op[i]      = mem_op[rd_ptr + vec_alu_pkg::rs_ptr_t'(i)];
      assign head_sew[i]     = mem_sew[rd_ptr + vec_alu_pkg::rs_ptr_t'(i)];
      assign head_vs1[i]     = mem_vs1[rd_ptr + vec_alu_pkg::rs_ptr_t'(i)];
      assign head_vs2[i]     = mem_vs2[rd_ptr + vec_alu_pkg::rs_ptr_t'(i)];
      assign head_rob_idx[i] = mem_rob_idx[rd_ptr + vec_alu_pkg::rs_ptr_t'(i)];
    end
    for (i = 1; i < vec_alu_pkg::num_alu; i = i + 1) begin : g_almost_empty
      // i or fewer entries held, so head i is not valid
      assign almost_empty[i] = (count <= vec_alu_pkg::rs_cnt_t'(i));
    end
  endgenerate

  // dispatch must watch full
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);

  // cluster pops only a low prefix of entries actually held
  a_pop_legal: assert property (@(posedge clk) disable iff (!rst_n)
    ((pop & (pop + 1'b1)) == '0) && (pop_cnt <= count));

endmodule

`default_nettype wire

/* verilog/vec_alu_shift.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_alu_shift (
  input  wire vec_alu_pkg::vreg_t vs2,
  input  wire vec_alu_pkg::vreg_t vs1,
  input  wire vec_alu_pkg::sew_e  sew,
  input  wire logic               shift_left,
  input  wire logic               shift_arith,
  output vec_alu_pkg::vreg_t      result
);

  // mirror bits inside each aligned element
  // for a power of two width, w-1-off is off ^ (w-1)
  function automatic vec_alu_pkg::vreg_t rev_elems(input vec_alu_pkg::vreg_t v,
                                                  input int unsigned msk);
    vec_alu_pkg::vreg_t r;
    for (int unsigned j = 0; j < vec_alu_pkg::vlen; j++) begin
      r[j] = v[j ^ msk];
    end
    return r;
  endfunction

  // element width minus one
  int unsigned        elem_msk;
  // shifter input, reversed for sll
  vec_alu_pkg::vreg_t src;
  // arithmetic right shifter output
  vec_alu_pkg::vreg_t shifted;

  always_comb begin
    elem_msk = (8 << sew) - 1;
    src      = shift_left ? rev_elems(vs2, elem_msk) : vs2;
    shifted  = '0;
    // fill bit is the sign only for sra, zero for srl and reversed sll
    case (sew)
      vec_alu_pkg::sew_e32: begin
        for (int k = 0; k < vec_alu_pkg::vlen / 32; k++) begin
          shifted[32*k +: 32] = 32'($signed({shift_arith & src[32*k+31], src[32*k +: 32]})
                                    >>> vs1[32*k +: 5]);
        end
      end
      vec_alu_pkg::sew_e16: begin
        for (int k = 0; k < vec_alu_pkg::vlen / 16; k++) begin
          shifted[16*k +: 16] = 16'($signed({shift_arith & src[16*k+15], src[16*k +: 16]})
                                    >>> vs1[16*k +: 4]);
        end
      end
      default: begin
        for (int k = 0; k < vec_alu_pkg::vlen / 8; k++) begin
          shifted[8*k +: 8] = 8'($signed({shift_arith & src[8*k+7], src[8*k +: 8]})
                                  >>> vs1[8*k +: 3]);
        end
      end
    endcase
  end

  // undo the reversal for sll
  assign result = shift_left ? rev_elems(shifted, elem_msk) : shifted;

endmodule

`default_nettype wire

/* verilog/vec_alu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_alu_top (
  input  wire logic                                            clk,
  input  wire logic                                            rst_n,
  // dispatch side
  input  wire logic                                            push,
  input  wire vec_alu_pkg::alu_op_e                            push_op,
  input  wire vec_alu_pkg::sew_e                               push_sew,
  input  wire vec_alu_pkg::vreg_t                              push_vs1,
  input  wire vec_alu_pkg::vreg_t                              push_vs2,
  input  wire vec_alu_pkg::rob_idx_t                           push_rob_idx,
  output logic                                                 full,
  // rob side
  output logic                       [vec_alu_pkg::num_alu-1:0] result_valid,
  output vec_alu_pkg::vreg_t         [vec_alu_pkg::num_alu-1:0] result,
  output vec_alu_pkg::rob_idx_t      [vec_alu_pkg::num_alu-1:0] result_rob_idx,
  input  wire logic                  [vec_alu_pkg::num_alu-1:0] result_ready
);

  // fifo to cluster
  vec_alu_pkg::alu_op_e  [vec_alu_pkg::num_alu-1:0] head_op;
  vec_alu_pkg::sew_e     [vec_alu_pkg::num_alu-1:0] head_sew;
  vec_alu_pkg::vreg_t    [vec_alu_pkg::num_alu-1:0] head_vs1;
  vec_alu_pkg::vreg_t    [vec_alu_pkg::num_alu-1:0] head_vs2;
  vec_alu_pkg::rob_idx_t [vec_alu_pkg::num_alu-1:0] head_rob_idx;
  logic                                             empty;
  logic                  [vec_alu_pkg::num_alu-1:1] almost_empty;
  // cluster back to fifo
  logic                  [vec_alu_pkg::num_alu-1:0] pop;

  vec_alu_rs_fifo u_rs_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (push),
    .push_op      (push_op),
    .push_sew     (push_sew),
    .push_vs1     (push_vs1),
    .push_vs2     (push_vs2),
    .push_rob_idx (push_rob_idx),
    .full         (full),
    .empty        (empty),
    .almost_empty (almost_empty),
    .head_op      (head_op),
    .head_sew     (head_sew),
    .head_vs1     (head_vs1),
    .head_vs2     (head_vs2),
    .head_rob_idx (head_rob_idx),
    .pop          (pop)
  );

  vec_alu_cluster u_cluster (
    .clk            (clk),
    .rst_n          (rst_n),
    .head_op        (head_op),
    .head_sew       (head_sew),
    .head_vs1       (head_vs1),
    .head_vs2       (head_vs2),
    .head_rob_idx   (head_rob_idx),
    .empty          (empty),
    .almost_empty   (almost_empty),
    .pop            (pop),
    .result_valid   (result_valid),
    .result         (result),
    .result_rob_idx (result_rob_idx),
    .result_ready   (result_ready)
  );

endmodule

`default_nettype wire

/* verilog/vec_alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_alu_unit (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  // uop from the reservation station head
  input  wire logic                  issue,
  input  wire vec_alu_pkg::alu_op_e  uop_op,
  input  wire vec_alu_pkg::sew_e     uop_sew,
  input  wire vec_alu_pkg::vreg_t    uop_vs1,
  input  wire vec_alu_pkg::vreg_t    uop_vs2,
  input  wire vec_alu_pkg::rob_idx_t uop_rob_idx,
  output logic                       can_accept,
  // result toward the rob
  output logic                       result_valid,
  output vec_alu_pkg::vreg_t         result,
  output vec_alu_pkg::rob_idx_t      result_rob_idx,
  input  wire logic                  result_ready
);

  // decoded controls
  logic                    sub;
  logic                    shift_left;
  logic                    shift_arith;
  vec_alu_pkg::elem_mask_t carry_break;

  // datapath outputs
  vec_alu_pkg::vreg_t sum;
  vec_alu_pkg::vreg_t shift_res;
  vec_alu_pkg::vreg_t logic_res;
  vec_alu_pkg::vreg_t next_result;

  assign sub         = (uop_op == vec_alu_pkg::op_sub);
  assign shift_left  = (uop_op == vec_alu_pkg::op_sll);
  assign shift_arith = (uop_op == vec_alu_pkg::op_sra);

  // element start every 2**sew bytes
  always_comb begin
    for (int k = 0; k < vec_alu_pkg::vlen_bytes; k++) begin
      carry_break[k] = ((k & ((1 << uop_sew) - 1)) == 0);
    end
  end

  vec_alu_addsub u_addsub (
    .a           (uop_vs2),
    .b           (uop_vs1),
    .sub         (sub),
    .carry_break (carry_break),
    .sum         (sum)
  );

  vec_alu_shift u_shift (
    .vs2         (uop_vs2),
    .vs1         (uop_vs1),
    .sew         (uop_sew),
    .shift_left  (shift_left),
    .shift_arith (shift_arith),
    .result      (shift_res)
  );

  vec_alu_logic u_logic (
    .vs2    (uop_vs2),
    .vs1    (uop_vs1),
    .op     (uop_op),
    .result (logic_res)
  );

  // pick the datapath by opcode class
  always_comb begin
    case (uop_op)
      vec_alu_pkg::op_add, vec_alu_pkg::op_sub:                     next_result = sum;
      vec_alu_pkg::op_sll, vec_alu_pkg::op_srl, vec_alu_pkg::op_sra: next_result = shift_res;
      default:                                                      next_result = logic_res;
    endcase
  end

  // free now, or the held result leaves this edge
  assign can_accept = !result_valid || result_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else if (issue) begin
      result_valid <= 1'b1;
    end else if (result_ready) begin
      result_valid <= 1'b0;
    end
  end

  // held while valid and not ready, since issue needs can_accept
  always_ff @(posedge clk) begin
    if (issue) begin
      result         <= next_result;
      result_rob_idx <= uop_rob_idx;
    end
  end

  // cluster gating must never overwrite a held result
  a_issue_ok: assert property (@(posedge clk) disable iff (!rst_n) issue |-> can_accept);

endmodule

`default_nettype wire
